//--- common/consolePkg.sv
`default_nettype none

package consolePkg;

    // one character cell, plain 8-bit ASCII
    typedef logic [7:0] charT;

    // control codes handled by the parser
    localparam charT ASCII_BS    = 8'h08;
    localparam charT ASCII_LF    = 8'h0A;
    localparam charT ASCII_CR    = 8'h0D;
    localparam charT ASCII_ESC   = 8'h1B;

    // fill for the clear sweep, also the space key
    localparam charT ASCII_SPACE = 8'h20;

    // escape sequence progress
    // clearing is the multi-cycle screen wipe after ESC [ 2 J
    typedef enum logic [2:0] {
        idle,
        gotEsc,
        gotBracket,
        gotTwo,
        clearing
    } parserStateT;

endpackage

`default_nettype wire

//--- uart/uartReceiver.sv
`default_nettype none

module uartReceiver #(
    parameter int CLKS_PER_BIT = 868
) (
    input  logic             clk,
    input  logic             rstN,
    input  logic             rx,
    output logic             rxValid,
    output consolePkg::charT rxData
);

    // counts up to one full bit period
    localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);

    typedef enum logic [1:0] {
        rxIdle,
        rxStart,
        rxBits,
        rxStop
    } rxStateT;

    rxStateT          state;
    logic [1:0]       rxSync;
    logic [CNT_W-1:0] clkCnt;
    logic [2:0]       bitCnt;

    always_ff @(posedge clk) begin
        // rx is asynchronous to clk
        rxSync  <= {rxSync[0], rx};
        rxValid <= 1'b0;
        if (!rstN) begin
            rxSync <= 2'b11;
            state  <= rxIdle;
            clkCnt <= '0;
            bitCnt <= '0;
        end else begin
            case (state)
                rxIdle: begin
                    clkCnt <= '0;
                    // low line means a start bit has begun
                    if (!rxSync[1]) begin
                        state <= rxStart;
                    end
                end
                rxStart: begin
                    // half a bit to land in the middle of the start bit
                    if (clkCnt == CNT_W'(CLKS_PER_BIT / 2 - 1)) begin
                        clkCnt <= '0;
                        bitCnt <= '0;
                        // a high line here was only a glitch
                        state  <= rxSync[1] ? rxIdle : rxBits;
                    end else begin
                        clkCnt <= clkCnt + 1'b1;
                    end
                end
                rxBits: begin
                    if (clkCnt == CNT_W'(CLKS_PER_BIT - 1)) begin
                        clkCnt <= '0;
                        bitCnt <= bitCnt + 1'b1;
                        // lsb arrives first so shift in from the top
                        rxData <= {rxSync[1], rxData[7:1]};
                        if (bitCnt == 3'd7) begin
                            state <= rxStop;
                        end
                    end else begin
                        clkCnt <= clkCnt + 1'b1;
                    end
                end
                default: begin
                    if (clkCnt == CNT_W'(CLKS_PER_BIT - 1)) begin
                        // low stop bit is a framing error and the byte is lost
                        rxValid <= rxSync[1];
                        state   <= rxIdle;
                    end else begin
                        clkCnt <= clkCnt + 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- uart/uartTransmitter.sv
`default_nettype none

module uartTransmitter #(
    parameter int CLKS_PER_BIT    = 868,
    parameter int TX_BUFFER_DEPTH = 4
) (
    input  logic             clk,
    input  logic             rstN,
    input  logic             txPush,
    input  consolePkg::charT txByte,
    output logic             txCredit,
    output logic             tx
);

    import consolePkg::*;

    localparam int PTR_W  = TX_BUFFER_DEPTH > 1 ? $clog2(TX_BUFFER_DEPTH) : 1;
    localparam int FILL_W = $clog2(TX_BUFFER_DEPTH + 1);
    localparam int CNT_W  = $clog2(CLKS_PER_BIT + 1);

    charT              buffer [TX_BUFFER_DEPTH];
    logic [PTR_W-1:0]  wrPtr;
    logic [PTR_W-1:0]  rdPtr;
    logic [FILL_W-1:0] fill;
    logic              busy;
    logic              pop;
    logic [9:0]        frame;
    logic [CNT_W-1:0]  clkCnt;
    logic [3:0]        bitCnt;

    // frame shifts out from bit 0 and refills with ones
    assign tx  = frame[0];
    // take the oldest byte as soon as the line is free
    assign pop = !busy && fill != '0;

    always_ff @(posedge clk) begin
        if (txPush) begin
            buffer[wrPtr] <= txByte;
        end
    end

    always_ff @(posedge clk) begin
        txCredit <= 1'b0;
        if (!rstN) begin
            wrPtr  <= '0;
            rdPtr  <= '0;
            fill   <= '0;
            busy   <= 1'b0;
            frame  <= '1;
            clkCnt <= '0;
            bitCnt <= '0;
        end else begin
            // circular pointers for any depth
            if (txPush) begin
                wrPtr <= (wrPtr == PTR_W'(TX_BUFFER_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
            end
            fill <= fill + FILL_W'(txPush) - FILL_W'(pop);
            if (pop) begin
                rdPtr    <= (rdPtr == PTR_W'(TX_BUFFER_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
                // stop bit, data, start bit
                frame    <= {1'b1, buffer[rdPtr], 1'b0};
                busy     <= 1'b1;
                clkCnt   <= '0;
                bitCnt   <= '0;
                // the freed slot goes back to the keyboard side
                txCredit <= 1'b1;
            end else if (busy) begin
                if (clkCnt == CNT_W'(CLKS_PER_BIT - 1)) begin
                    clkCnt <= '0;
                    frame  <= {1'b1, frame[9:1]};
                    // ten bits per frame
                    if (bitCnt == 4'd9) begin
                        busy <= 1'b0;
                    end else begin
                        bitCnt <= bitCnt + 1'b1;
                    end
                end else begin
                    clkCnt <= clkCnt + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- keyboard/ps2Receiver.sv
`default_nettype none

module ps2Receiver (
    input  logic       clk,
    input  logic       rstN,
    input  logic       ps2Clk,
    input  logic       ps2Data,
    output logic       scanValid,
    output logic [7:0] scanCode,
    output logic       shiftHeld
);

    logic [2:0]  clkSync;
    logic [1:0]  dataSync;
    logic        fallEdge;
    logic [9:0]  frame;
    logic [3:0]  bitCnt;
    logic [10:0] fullFrame;
    logic [7:0]  code;
    logic        frameOk;
    logic        breakSeen;
    logic        extSeen;

    // device changes data on rising ps2Clk so sample on the fall
    assign fallEdge  = clkSync[2] && !clkSync[1];
    // the stop bit completes the frame in this cycle
    assign fullFrame = {dataSync[1], frame};
    assign code      = fullFrame[8:1];
    // start low, stop high, odd parity over data plus parity bit
    assign frameOk   = !fullFrame[0] && fullFrame[10] && ^fullFrame[9:1];

    always_ff @(posedge clk) begin
        clkSync   <= {clkSync[1:0], ps2Clk};
        dataSync  <= {dataSync[0], ps2Data};
        scanValid <= 1'b0;
        if (!rstN) begin
            // both lines idle high
            clkSync   <= '1;
            dataSync  <= '1;
            bitCnt    <= '0;
            breakSeen <= 1'b0;
            extSeen   <= 1'b0;
            shiftHeld <= 1'b0;
        end else if (fallEdge) begin
            if (bitCnt != 4'd10) begin
                frame  <= {dataSync[1], frame[9:1]};
                bitCnt <= bitCnt + 1'b1;
            end else begin
                bitCnt <= '0;
                if (frameOk) begin
                    // prefixes only mark the next code
                    if (code == 8'hF0) begin
                        breakSeen <= 1'b1;
                    end else if (code == 8'hE0) begin
                        extSeen <= 1'b1;
                    end else begin
                        breakSeen <= 1'b0;
                        extSeen   <= 1'b0;
                        // left and right shift only move the shift flag
                        if (!extSeen && (code == 8'h12 || code == 8'h59)) begin
                            shiftHeld <= !breakSeen;
                        end else if (!extSeen && !breakSeen) begin
                            scanValid <= 1'b1;
                            scanCode  <= code;
                        end
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- keyboard/keyboardEncoder.sv
`default_nettype none

module keyboardEncoder #(
    parameter int TX_BUFFER_DEPTH = 4
) (
    input  logic             clk,
    input  logic             rstN,
    input  logic             scanValid,
    input  logic [7:0]       scanCode,
    input  logic             shiftHeld,
    input  logic             txCredit,
    output logic             txPush,
    output consolePkg::charT txByte
);

    import consolePkg::*;

    localparam int CREDIT_W = $clog2(TX_BUFFER_DEPTH + 1);

    charT                ascii;
    logic                isLetter;
    logic                mapped;
    logic [CREDIT_W-1:0] credits;
    logic                push;

    // no credit left means the key is dropped
    assign push = scanValid && mapped && credits != '0;

    // scan code set 2 to ASCII
    always_comb begin
        ascii    = '0;
        isLetter = 1'b1;
        mapped   = 1'b1;
        case (scanCode)
            8'h1C: ascii = "a";
            8'h32: ascii = "b";
            8'h21: ascii = "c";
            8'h23: ascii = "d";
            8'h24: ascii = "e";
            8'h2B: ascii = "f";
            8'h34: ascii = "g";
            8'h33: ascii = "h";
            8'h43: ascii = "i";
            8'h3B: ascii = "j";
            8'h42: ascii = "k";
            8'h4B: ascii = "l";
            8'h3A: ascii = "m";
            8'h31: ascii = "n";
            8'h44: ascii = "o";
            8'h4D: ascii = "p";
            8'h15: ascii = "q";
            8'h2D: ascii = "r";
            8'h1B: ascii = "s";
            8'h2C: ascii = "t";
            8'h3C: ascii = "u";
            8'h2A: ascii = "v";
            8'h1D: ascii = "w";
            8'h22: ascii = "x";
            8'h35: ascii = "y";
            8'h1A: ascii = "z";
            default: isLetter = 1'b0;
        endcase
        if (isLetter) begin
            // upper case sits 0x20 below lower case
            if (shiftHeld) begin
                ascii = ascii - 8'h20;
            end
        end else begin
            case (scanCode)
                8'h16: ascii = shiftHeld ? "!" : "1";
                8'h1E: ascii = shiftHeld ? "@" : "2";
                8'h26: ascii = shiftHeld ? "#" : "3";
                8'h25: ascii = shiftHeld ? "$" : "4";
                8'h2E: ascii = shiftHeld ? "%" : "5";
                8'h36: ascii = shiftHeld ? "^" : "6";
                8'h3D: ascii = shiftHeld ? "&" : "7";
                8'h3E: ascii = shiftHeld ? "*" : "8";
                8'h46: ascii = shiftHeld ? "(" : "9";
                8'h45: ascii = shiftHeld ? ")" : "0";
                8'h29: ascii = ASCII_SPACE;
                // enter goes out as a bare CR
                8'h5A: ascii = ASCII_CR;
                8'h66: ascii = ASCII_BS;
                default: mapped = 1'b0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        txByte <= ascii;
        if (!rstN) begin
            // one credit per transmit buffer slot
            credits <= CREDIT_W'(TX_BUFFER_DEPTH);
            txPush  <= 1'b0;
        end else begin
            txPush  <= push;
            // spent on push and returned on each txCredit pulse
            credits <= credits - CREDIT_W'(push) + CREDIT_W'(txCredit);
        end
    end

endmodule

`default_nettype wire

//--- logic/vt100Parser.sv
`default_nettype none

module vt100Parser #(
    parameter int  CONSOLE_LINES   = 40,
    parameter int  CONSOLE_COLUMNS = 80,
    localparam int CELLS  = CONSOLE_LINES * CONSOLE_COLUMNS,
    localparam int ADDR_W = CELLS > 1 ? $clog2(CELLS) : 1,
    localparam int ROW_W  = CONSOLE_LINES > 1 ? $clog2(CONSOLE_LINES) : 1,
    localparam int COL_W  = CONSOLE_COLUMNS > 1 ? $clog2(CONSOLE_COLUMNS) : 1
) (
    input  logic              clk,
    input  logic              rstN,
    input  logic              rxValid,
    input  consolePkg::charT  rxData,
    output logic              writeEnable,
    output logic [ADDR_W-1:0] writeAddr,
    output consolePkg::charT  writeChar,
    output logic [ROW_W-1:0]  cursorRow,
    output logic [COL_W-1:0]  cursorCol
);

    import consolePkg::*;

    parserStateT       state;
    logic [ADDR_W-1:0] sweepAddr;
    logic              lastCol;
    logic [ROW_W-1:0]  nextRow;
    logic              printable;

    assign lastCol   = cursorCol == COL_W'(CONSOLE_COLUMNS - 1);
    // no scrolling so the bottom line wraps to the top
    assign nextRow   = (cursorRow == ROW_W'(CONSOLE_LINES - 1)) ? '0 : cursorRow + 1'b1;
    assign printable = rxData >= 8'h20 && rxData <= 8'h7E;

    always_ff @(posedge clk) begin
        writeEnable <= 1'b0;
        if (!rstN) begin
            state     <= idle;
            cursorRow <= '0;
            cursorCol <= '0;
            sweepAddr <= '0;
        end else begin
            case (state)
                idle: begin
                    if (rxValid && printable) begin
                        // cell at the cursor then step right
                        writeEnable <= 1'b1;
                        writeAddr   <= ADDR_W'(cursorRow * CONSOLE_COLUMNS + cursorCol);
                        writeChar   <= rxData;
                        cursorCol   <= lastCol ? '0 : cursorCol + 1'b1;
                        if (lastCol) begin
                            cursorRow <= nextRow;
                        end
                    end else if (rxValid) begin
                        case (rxData)
                            ASCII_CR: cursorCol <= '0;
                            ASCII_LF: cursorRow <= nextRow;
                            ASCII_BS: begin
                                // stops at column 0
                                if (cursorCol != '0) begin
                                    cursorCol <= cursorCol - 1'b1;
                                end
                            end
                            ASCII_ESC: state <= gotEsc;
                            default: ;
                        endcase
                    end
                end
                gotEsc: begin
                    if (rxValid) begin
                        state <= (rxData == "[") ? gotBracket : idle;
                    end
                end
                gotBracket: begin
                    if (rxValid) begin
                        state <= (rxData == "2") ? gotTwo : idle;
                        // ESC [ H
                        if (rxData == "H") begin
                            cursorRow <= '0;
                            cursorCol <= '0;
                        end
                    end
                end
                gotTwo: begin
                    if (rxValid && rxData == "J") begin
                        // first cell goes out right away
                        writeEnable <= 1'b1;
                        writeAddr   <= '0;
                        writeChar   <= ASCII_SPACE;
                        sweepAddr   <= ADDR_W'(1);
                        state       <= clearing;
                    end else if (rxValid) begin
                        state <= idle;
                    end
                end
                clearing: begin
                    // one cell per cycle, rx must stay quiet meanwhile
                    writeEnable <= 1'b1;
                    writeAddr   <= sweepAddr;
                    writeChar   <= ASCII_SPACE;
                    sweepAddr   <= sweepAddr + 1'b1;
                    if (sweepAddr == ADDR_W'(CELLS - 1)) begin
                        state     <= idle;
                        cursorRow <= '0;
                        cursorCol <= '0;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/textRam.sv
`default_nettype none

module textRam #(
    parameter int  CONSOLE_LINES   = 40,
    parameter int  CONSOLE_COLUMNS = 80,
    localparam int CELLS  = CONSOLE_LINES * CONSOLE_COLUMNS,
    localparam int ADDR_W = CELLS > 1 ? $clog2(CELLS) : 1
) (
    input  logic              clk,
    input  logic              writeEnable,
    input  logic [ADDR_W-1:0] writeAddr,
    input  consolePkg::charT  writeChar,
    input  logic [ADDR_W-1:0] readAddr,
    output consolePkg::charT  readChar
);

    import consolePkg::*;

    // row-major, line times columns plus column
    charT cells [CELLS];

    always_ff @(posedge clk) begin
        // parser port
        if (writeEnable) begin
            cells[writeAddr] <= writeChar;
        end
        // display port, one cycle latency
        // same-cell collision returns the old character
        readChar <= cells[readAddr];
    end

endmodule

`default_nettype wire

//--- logic/fpgaVirtualConsole.sv
`default_nettype none

// the clear sweep takes CONSOLE_LINES * CONSOLE_COLUMNS cycles and the
// receiver cannot be held off, so the sweep has to finish inside one
// frame time: CONSOLE_LINES * CONSOLE_COLUMNS < 10 * CLKS_PER_BIT
module fpgaVirtualConsole #(
    // 100 MHz at 115200 baud
    parameter int  CLKS_PER_BIT    = 868,
    parameter int  CONSOLE_LINES   = 40,
    parameter int  CONSOLE_COLUMNS = 80,
    parameter int  TX_BUFFER_DEPTH = 4,
    localparam int CELLS  = CONSOLE_LINES * CONSOLE_COLUMNS,
    localparam int ADDR_W = CELLS > 1 ? $clog2(CELLS) : 1,
    localparam int ROW_W  = CONSOLE_LINES > 1 ? $clog2(CONSOLE_LINES) : 1,
    localparam int COL_W  = CONSOLE_COLUMNS > 1 ? $clog2(CONSOLE_COLUMNS) : 1
) (
    input  logic              clk,
    input  logic              rstN,
    input  logic              ps2Clk,
    input  logic              ps2Data,
    input  logic              uartRx,
    output logic              uartTx,
    input  logic [ADDR_W-1:0] readAddr,
    output consolePkg::charT  readChar,
    output logic [ROW_W-1:0]  cursorRow,
    output logic [COL_W-1:0]  cursorCol
);

    import consolePkg::*;

    // keyboard side
    logic       scanValid;
    logic [7:0] scanCode;
    logic       shiftHeld;
    logic       txPush;
    charT       txByte;
    logic       txCredit;

    // console side
    logic              rxValid;
    charT              rxData;
    logic              writeEnable;
    logic [ADDR_W-1:0] writeAddr;
    charT              writeChar;

    ps2Receiver kbUnit (
        .clk, .rstN, .ps2Clk, .ps2Data, .scanValid, .scanCode, .shiftHeld
    );

    keyboardEncoder #(.TX_BUFFER_DEPTH(TX_BUFFER_DEPTH)) encUnit (
        .clk, .rstN, .scanValid, .scanCode, .shiftHeld, .txCredit, .txPush, .txByte
    );

    // credits keep this buffer from overflowing
    uartTransmitter #(
        .CLKS_PER_BIT(CLKS_PER_BIT),
        .TX_BUFFER_DEPTH(TX_BUFFER_DEPTH)
    ) txUnit (
        .clk, .rstN, .txPush, .txByte, .txCredit, .tx(uartTx)
    );

    uartReceiver #(.CLKS_PER_BIT(CLKS_PER_BIT)) rxUnit (
        .clk, .rstN, .rx(uartRx), .rxValid, .rxData
    );

    vt100Parser #(
        .CONSOLE_LINES(CONSOLE_LINES),
        .CONSOLE_COLUMNS(CONSOLE_COLUMNS)
    ) parserUnit (
        .clk, .rstN, .rxValid, .rxData, .writeEnable, .writeAddr, .writeChar,
        .cursorRow, .cursorCol
    );

    // second port is left for an external display reader
    textRam #(
        .CONSOLE_LINES(CONSOLE_LINES),
        .CONSOLE_COLUMNS(CONSOLE_COLUMNS)
    ) ramUnit (
        .clk, .writeEnable, .writeAddr, .writeChar, .readAddr, .readChar
    );

endmodule

`default_nettype wire

//--- verif/consoleTb.sv
`default_nettype none

module consoleTb;

    timeunit 1ns;
    timeprecision 1ps;

    import consolePkg::*;

    localparam int CLKS_PER_BIT    = 8;
    localparam int LINES           = 4;
    localparam int COLS            = 8;
    localparam int TX_BUFFER_DEPTH = 4;
    localparam int CELLS           = LINES * COLS;
    localparam int ADDR_W          = $clog2(CELLS);
    localparam int ROW_W           = $clog2(LINES);
    localparam int COL_W           = $clog2(COLS);
    // about 90 bytes, 30 key frames and screen reads, with margin
    localparam int MAX_CYCLES      = 40000;
    localparam int PS2_HALF        = 4;

    // scan code set 2, letters a to z, then digits 1 to 0
    localparam logic [26*8-1:0] LETTER_CODES = {
        8'h1C, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2B, 8'h34, 8'h33, 8'h43, 8'h3B,
        8'h42, 8'h4B, 8'h3A, 8'h31, 8'h44, 8'h4D, 8'h15, 8'h2D, 8'h1B, 8'h2C,
        8'h3C, 8'h2A, 8'h1D, 8'h22, 8'h35, 8'h1A
    };
    localparam logic [10*8-1:0] DIGIT_CODES = {
        8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E, 8'h36, 8'h3D, 8'h3E, 8'h46, 8'h45
    };
    localparam logic [10*8-1:0] DIGIT_PLAIN = "1234567890";
    localparam logic [10*8-1:0] DIGIT_SHIFT = "!@#$%^&*()";

    logic              clk = 1'b0;
    logic              rstN;
    logic              ps2Clk;
    logic              ps2Data;
    logic              uartRx;
    logic              uartTx;
    logic [ADDR_W-1:0] readAddr;
    charT              readChar;
    logic [ROW_W-1:0]  cursorRow;
    logic [COL_W-1:0]  cursorCol;

    integer seed;
    int     cycleCount = 0;
    int     errors = 0;
    int     checks = 0;
    int     testsRun = 0;
    int     testStartErrors = 0;

    // screen model and its escape state
    charT model [CELLS];
    int   mRow;
    int   mCol;
    int   mState;

    charT txQueue[$];
    charT expQueue[$];

    fpgaVirtualConsole #(
        .CLKS_PER_BIT(CLKS_PER_BIT),
        .CONSOLE_LINES(LINES),
        .CONSOLE_COLUMNS(COLS),
        .TX_BUFFER_DEPTH(TX_BUFFER_DEPTH)
    ) dut_i (
        .clk(clk), .rstN(rstN), .ps2Clk(ps2Clk), .ps2Data(ps2Data),
        .uartRx(uartRx), .uartTx(uartTx), .readAddr(readAddr),
        .readChar(readChar), .cursorRow(cursorRow), .cursorCol(cursorCol)
    );

    always #5 clk = !clk;

    // run limit
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Regression failed");
            $finish;
        end
    end

    // decode uartTx frames, sampling mid-bit on falling clock
    initial begin
        charT bits;
        forever begin
            @(negedge clk);
            if (uartTx === 1'b0) begin
                repeat (CLKS_PER_BIT / 2) @(negedge clk);
                for (int i = 0; i < 8; i++) begin
                    repeat (CLKS_PER_BIT) @(negedge clk);
                    bits[i] = uartTx;
                end
                repeat (CLKS_PER_BIT) @(negedge clk);
                if (uartTx !== 1'b1) begin
                    $display("[ERROR] %0t: uartTx stop bit was low", $time);
                    errors++;
                end
                txQueue.push_back(bits);
            end
        end
    end

    // 8N1, lsb first, one idle bit after the stop bit
    task automatic sendSerial(input charT b);
        logic [9:0] bits;
        bits = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            uartRx <= bits[i];
            repeat (CLKS_PER_BIT - 1) @(posedge clk);
        end
        repeat (CLKS_PER_BIT) @(posedge clk);
    endtask

    // cursor rules and the two escape sequences
    task automatic modelApply(input charT b);
        case (mState)
            0: begin
                if (b >= 8'h20 && b <= 8'h7E) begin
                    model[mRow * COLS + mCol] = b;
                    mCol++;
                    if (mCol == COLS) begin
                        mCol = 0;
                        mRow = (mRow + 1) % LINES;
                    end
                end else if (b == ASCII_CR) begin
                    mCol = 0;
                end else if (b == ASCII_LF) begin
                    mRow = (mRow + 1) % LINES;
                end else if (b == ASCII_BS && mCol > 0) begin
                    mCol--;
                end else if (b == ASCII_ESC) begin
                    mState = 1;
                end
            end
            1: mState = (b == "[") ? 2 : 0;
            2: begin
                if (b == "H") begin
                    mRow = 0;
                    mCol = 0;
                end
                mState = (b == "2") ? 3 : 0;
            end
            default: begin
                if (b == "J") begin
                    for (int a = 0; a < CELLS; a++) begin
                        model[a] = ASCII_SPACE;
                    end
                    mRow = 0;
                    mCol = 0;
                end
                mState = 0;
            end
        endcase
    endtask

    task automatic sendChar(input charT b);
        sendSerial(b);
        modelApply(b);
    endtask

    task automatic checkScreen(input string what);
        charT got;
        for (int a = 0; a < CELLS; a++) begin
            @(posedge clk);
            readAddr <= ADDR_W'(a);
            @(posedge clk);
            @(negedge clk);
            got = readChar;
            checks++;
            if (got !== model[a]) begin
                $display("[ERROR] %0t: %s, cell %0d reads %h, expected %h",
                         $time, what, a, got, model[a]);
                errors++;
            end
        end
    endtask

    task automatic checkCursor(input string what);
        @(negedge clk);
        checks++;
        if (cursorRow !== ROW_W'(mRow) || cursorCol !== COL_W'(mCol)) begin
            $display("[ERROR] %0t: %s, cursor at %0d,%0d, expected %0d,%0d",
                     $time, what, cursorRow, cursorCol, mRow, mCol);
            errors++;
        end
    endtask

    // start, data lsb first, odd parity, stop
    task automatic sendPs2(input logic [7:0] code, input int half);
        logic [10:0] bits;
        bits = {1'b1, ~^code, code, 1'b0};
        for (int i = 0; i < 11; i++) begin
            @(posedge clk);
            ps2Data <= bits[i];
            repeat (half) @(posedge clk);
            ps2Clk <= 1'b0;
            repeat (half) @(posedge clk);
            ps2Clk <= 1'b1;
        end
        repeat (2 * half) @(posedge clk);
    endtask

    task automatic pressKey(input logic [7:0] code, input logic shift, input int half);
        if (shift) begin
            sendPs2(8'h12, half);
        end
        sendPs2(code, half);
        sendPs2(8'hF0, half);
        sendPs2(code, half);
        if (shift) begin
            sendPs2(8'hF0, half);
            sendPs2(8'h12, half);
        end
    endtask

    // 0-25 letters, 26-35 digits, 36 space, 37 enter, 38 backspace
    task automatic lookupKey(input int idx, input logic shift,
                             output logic [7:0] code, output charT ch);
        if (idx < 26) begin
            code = LETTER_CODES[8*(25-idx) +: 8];
            ch   = (shift ? 8'h41 : 8'h61) + 8'(idx);
        end else if (idx < 36) begin
            code = DIGIT_CODES[8*(35-idx) +: 8];
            ch   = shift ? DIGIT_SHIFT[8*(35-idx) +: 8] : DIGIT_PLAIN[8*(35-idx) +: 8];
        end else if (idx == 36) begin
            code = 8'h29;
            ch   = ASCII_SPACE;
        end else if (idx == 37) begin
            code = 8'h5A;
            ch   = ASCII_CR;
        end else begin
            code = 8'h66;
            ch   = ASCII_BS;
        end
    endtask

    task automatic checkTx(input string what);
        charT got;
        charT want;
        while (txQueue.size() < expQueue.size()) begin
            @(posedge clk);
        end
        // quiet window so a stray extra byte shows up
        repeat (20 * CLKS_PER_BIT) @(posedge clk);
        checks++;
        if (txQueue.size() != expQueue.size()) begin
            $display("[ERROR] %0t: %s, uartTx sent %0d bytes, expected %0d",
                     $time, what, txQueue.size(), expQueue.size());
            errors++;
        end
        while (txQueue.size() > 0 && expQueue.size() > 0) begin
            got  = txQueue.pop_front();
            want = expQueue.pop_front();
            checks++;
            if (got !== want) begin
                $display("[ERROR] %0t: %s, uartTx byte %h, expected %h", $time, what, got, want);
                errors++;
            end
        end
        txQueue.delete();
        expQueue.delete();
    endtask

    task automatic endTest(input string name);
        testsRun++;
        $display("%s: done, %0d errors", name, errors - testStartErrors);
        testStartErrors = errors;
    endtask

    initial begin
        int         keyIdx;
        logic       shiftOn;
        logic [7:0] code;
        charT       ch;
        logic [7:0] burstCodes [TX_BUFFER_DEPTH];
        seed     = 72;
        rstN     = 1'b0;
        uartRx   = 1'b1;
        ps2Clk   = 1'b1;
        ps2Data  = 1'b1;
        readAddr = '0;
        mRow     = 0;
        mCol     = 0;
        mState   = 0;
        repeat (8) @(posedge clk);
        rstN <= 1'b1;
        repeat (4) @(posedge clk);

        sendChar(ASCII_ESC);
        sendChar("[");
        sendChar("2");
        sendChar("J");
        // sweep length is one cycle per cell
        repeat (CELLS) @(posedge clk);
        checkScreen("clear");
        checkCursor("clear");
        endTest("test 1 clear screen");

        // start on the last line so the text wraps to line 0
        repeat (3) sendChar(ASCII_LF);
        for (int k = 0; k < 20; k++) begin
            sendChar(8'h20 + 8'({$random(seed)} % 95));
        end
        checkScreen("printable");
        checkCursor("printable");
        endTest("test 2 printable wrap");

        sendChar(ASCII_CR);
        sendChar(ASCII_BS);
        checkCursor("backspace at column 0");
        for (int k = 0; k < 30; k++) begin
            case ({$random(seed)} % 8)
                0: ch = ASCII_CR;
                1: ch = ASCII_LF;
                2: ch = ASCII_BS;
                default: ch = 8'h20 + 8'({$random(seed)} % 95);
            endcase
            sendChar(ch);
        end
        checkScreen("control mix");
        checkCursor("control mix");
        endTest("test 3 control codes");

        sendChar(ASCII_ESC);
        sendChar("[");
        sendChar("H");
        checkCursor("home");
        checkScreen("home");
        // both bad sequences swallow their last byte
        sendChar(ASCII_ESC);
        sendChar("K");
        sendChar(ASCII_ESC);
        sendChar("[");
        sendChar("Q");
        sendChar("Z");
        checkScreen("broken sequence");
        checkCursor("broken sequence");
        endTest("test 4 home and broken sequence");

        for (int k = 0; k < 10; k++) begin
            keyIdx  = {$random(seed)} % 39;
            shiftOn = 1'({$random(seed)} % 2);
            lookupKey(keyIdx, shiftOn, code, ch);
            expQueue.push_back(ch);
            pressKey(code, shiftOn, PS2_HALF);
        end
        checkTx("key presses");
        endTest("test 5 keyboard to uart");

        // fast keyboard clock so make codes outrun the serial line
        for (int k = 0; k < TX_BUFFER_DEPTH; k++) begin
            keyIdx = {$random(seed)} % 26;
            lookupKey(keyIdx, 1'b0, code, ch);
            burstCodes[k] = code;
            expQueue.push_back(ch);
            sendPs2(code, 2);
        end
        for (int k = 0; k < TX_BUFFER_DEPTH; k++) begin
            sendPs2(8'hF0, 2);
            sendPs2(burstCodes[k], 2);
        end
        checkTx("key burst");
        endTest("test 6 credit burst");

        $display("tests: %0d, checks: %0d, errors: %0d", testsRun, checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- fpgaVirtualConsole.f
common/consolePkg.sv
uart/uartReceiver.sv
uart/uartTransmitter.sv
keyboard/ps2Receiver.sv
keyboard/keyboardEncoder.sv
logic/vt100Parser.sv
logic/textRam.sv
logic/fpgaVirtualConsole.sv
verif/consoleTb.sv

//--- Bender.yml
package:
  name: fpgaVirtualConsole

sources:
  - common/consolePkg.sv
  - uart/uartReceiver.sv
  - uart/uartTransmitter.sv
  - keyboard/ps2Receiver.sv
  - keyboard/keyboardEncoder.sv
  - logic/vt100Parser.sv
  - logic/textRam.sv
  - logic/fpgaVirtualConsole.sv
  - target: simulation
    files:
      - verif/consoleTb.sv
